// ==== tlu_pkg.sv ====
// register map, widths and data-word layout shared by all trigger controller RTL files
package tlu_pkg;

    localparam int bus_addr_w = 16;
    typedef logic [bus_addr_w-1:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    localparam int trig_w = 8; // trigger and veto inputs
    typedef logic [trig_w-1:0] trig_vec_t;

    typedef logic [31:0] cnt_t;

    // fifo word, marker set on every trigger word
    typedef struct packed {
        logic        marker;
        logic [30:0] count; // counter before this trigger's increment
    } data_word_t;

    localparam bus_data_t tlu_version = 8'd5;

    localparam bus_addr_t addr_version_rst = 16'd0; // read version, write soft reset
    localparam bus_addr_t addr_conf        = 16'd1;
    localparam bus_addr_t addr_cnt0        = 16'd8;
    localparam bus_addr_t addr_cnt1        = 16'd9;
    localparam bus_addr_t addr_cnt2        = 16'd10;
    localparam bus_addr_t addr_cnt3        = 16'd11; // write loads the counter
    localparam bus_addr_t addr_lost        = 16'd12; // read only
    localparam bus_addr_t addr_trig_sel    = 16'd13;
    localparam bus_addr_t addr_veto_sel    = 16'd14;
    localparam bus_addr_t addr_trig_inv    = 16'd15;
    localparam bus_addr_t addr_max0        = 16'd16;
    localparam bus_addr_t addr_max1        = 16'd17;
    localparam bus_addr_t addr_max2        = 16'd18;
    localparam bus_addr_t addr_max3        = 16'd19;
    localparam bus_addr_t addr_last        = 16'd19;

    localparam int conf_enable_bit = 3; // trigger enable inside the conf byte

    localparam trig_vec_t veto_sel_rst = '1; // all vetoes active after reset

    localparam int sync_stages = 3;

endpackage

// ==== tlu_conf_if.sv ====
// configuration from the bus register block to the trigger logic, counter status back
`timescale 1ns/10ps

interface tlu_conf_if;
    import tlu_pkg::*;

    trig_vec_t trig_select;
    trig_vec_t trig_invert;
    trig_vec_t veto_select;
    logic      conf_enable;
    cnt_t      cnt_max;       // 0 means no limit
    logic      cnt_set;       // one-cycle preset strobe
    cnt_t      cnt_set_value;
    cnt_t      cnt_value;     // live trigger counter

    modport regs (
        output trig_select,
        output trig_invert,
        output veto_select,
        output conf_enable,
        output cnt_max,
        output cnt_set,
        output cnt_set_value,
        input  cnt_value
    );

    modport trig (
        input  trig_select,
        input  trig_invert,
        input  veto_select,
        input  conf_enable,
        input  cnt_max,
        input  cnt_set,
        input  cnt_set_value,
        output cnt_value
    );

endinterface

// ==== tlu_bus_regs.sv ====
// 8-bit bus register block: soft reset, configuration storage and counter readback
`timescale 1ns/10ps

module tlu_bus_regs (
    input  logic               BUS_CLK,
    input  logic               RST,
    input  tlu_pkg::bus_addr_t bus_add,
    input  tlu_pkg::bus_data_t bus_data_in,
    input  logic               bus_rd,
    input  logic               bus_wr,
    input  tlu_pkg::bus_data_t lost_count,
    output tlu_pkg::bus_data_t bus_data_out,
    output logic               sys_rst,
    tlu_conf_if.regs           conf
);
    import tlu_pkg::*;

    logic      soft_rst;     // one cycle after a write to address 0
    bus_data_t conf_reg;
    trig_vec_t trig_sel_reg;
    trig_vec_t veto_sel_reg;
    trig_vec_t trig_inv_reg;
    logic [23:0] cnt_low;    // preset bytes 8 to 10
    cnt_t      max_reg;
    cnt_t      cnt_buf;      // snapshot for consistent multi-byte reads

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= bus_wr && (bus_add == addr_version_rst);
    end

    assign sys_rst = RST | soft_rst;

    always_ff @(posedge BUS_CLK)
    begin
        if (sys_rst)
        begin
            conf_reg     <= '0;
            trig_sel_reg <= '0;
            veto_sel_reg <= veto_sel_rst;
            trig_inv_reg <= '0;
            cnt_low      <= '0;
            max_reg      <= '0;
        end
        else if (bus_wr && bus_add <= addr_last)
        begin
            case (bus_add)
                addr_conf:     conf_reg        <= bus_data_in;
                addr_cnt0:     cnt_low[7:0]    <= bus_data_in;
                addr_cnt1:     cnt_low[15:8]   <= bus_data_in;
                addr_cnt2:     cnt_low[23:16]  <= bus_data_in;
                addr_trig_sel: trig_sel_reg    <= bus_data_in;
                addr_veto_sel: veto_sel_reg    <= bus_data_in;
                addr_trig_inv: trig_inv_reg    <= bus_data_in;
                addr_max0:     max_reg[7:0]    <= bus_data_in;
                addr_max1:     max_reg[15:8]   <= bus_data_in;
                addr_max2:     max_reg[23:16]  <= bus_data_in;
                addr_max3:     max_reg[31:24]  <= bus_data_in;
                default:       ; // version, cnt3 and lost are not stored
            endcase
        end
    end

    // counter preset happens on the same edge as the top byte write
    assign conf.cnt_set       = bus_wr && (bus_add == addr_cnt3);
    assign conf.cnt_set_value = {bus_data_in, cnt_low};

    assign conf.trig_select = trig_sel_reg;
    assign conf.trig_invert = trig_inv_reg;
    assign conf.veto_select = veto_sel_reg;
    assign conf.conf_enable = conf_reg[conf_enable_bit];
    assign conf.cnt_max     = max_reg;

    // registered readback, holds between reads
    always_ff @(posedge BUS_CLK)
    begin
        if (sys_rst)
        begin
            bus_data_out <= '0;
            cnt_buf      <= '0;
        end
        else if (bus_rd)
        begin
            case (bus_add)
                addr_version_rst: bus_data_out <= tlu_version;
                addr_conf:        bus_data_out <= conf_reg;
                addr_cnt0:
                begin
                    bus_data_out <= conf.cnt_value[7:0]; // live byte
                    cnt_buf      <= conf.cnt_value;
                end
                addr_cnt1:        bus_data_out <= cnt_buf[15:8];
                addr_cnt2:        bus_data_out <= cnt_buf[23:16];
                addr_cnt3:        bus_data_out <= cnt_buf[31:24];
                addr_lost:        bus_data_out <= lost_count;
                addr_trig_sel:    bus_data_out <= trig_sel_reg;
                addr_veto_sel:    bus_data_out <= veto_sel_reg;
                addr_trig_inv:    bus_data_out <= trig_inv_reg;
                addr_max0:        bus_data_out <= max_reg[7:0];
                addr_max1:        bus_data_out <= max_reg[15:8];
                addr_max2:        bus_data_out <= max_reg[23:16];
                addr_max3:        bus_data_out <= max_reg[31:24];
                default:          bus_data_out <= '0; // 2 to 7 and unmapped
            endcase
        end
    end

endmodule

// ==== tlu_trigger_input.sv ====
// trigger and veto masking, input synchronisers and trigger rising-edge detection
`timescale 1ns/10ps

module tlu_trigger_input (
    input  logic               BUS_CLK,
    input  logic               sys_rst,
    input  tlu_pkg::trig_vec_t trigger,
    input  tlu_pkg::trig_vec_t trigger_veto,
    output logic               trig_edge,
    output logic               veto,
    tlu_conf_if.trig           conf
);
    import tlu_pkg::*;

    trig_vec_t trig_masked;
    logic      trig_or;
    logic      veto_or;
    logic [sync_stages-1:0] trig_sync;
    logic [sync_stages-1:0] veto_sync;
    logic      trig_last; // edge register

    // invert first, then select
    assign trig_masked = (trigger ^ conf.trig_invert) & conf.trig_select;
    assign trig_or     = |trig_masked;
    assign veto_or     = |(trigger_veto & conf.veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (sys_rst)
        begin
            trig_sync <= '0;
            veto_sync <= '0;
            trig_last <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[sync_stages-2:0], trig_or};
            veto_sync <= {veto_sync[sync_stages-2:0], veto_or};
            trig_last <= trig_sync[sync_stages-1];
        end
    end

    assign trig_edge = trig_sync[sync_stages-1] & ~trig_last; // one cycle on rise
    assign veto      = veto_sync[sync_stages-1];

endmodule

// ==== tlu_trigger_fsm.sv ====
// trigger acceptance FSM with trigger counter, limit check and fifo word generation
`timescale 1ns/10ps

module tlu_trigger_fsm (
    input  logic                BUS_CLK,
    input  logic                sys_rst,
    input  logic                trig_edge,
    input  logic                veto,
    input  logic                trigger_enable,
    input  logic                trigger_acknowledge,
    output logic                trigger_accepted_flag,
    output logic                data_write,
    output tlu_pkg::data_word_t data_word,
    tlu_conf_if.trig            conf
);
    import tlu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_accept,
        st_wait_ack
    } state_t;

    state_t state;
    state_t state_next;
    cnt_t   cnt;
    logic   trig_en;        // registered enable request
    logic   limit_reached;

    always_ff @(posedge BUS_CLK)
    begin
        if (sys_rst)
        begin
            state         <= st_idle;
            trig_en       <= 1'b0;
            limit_reached <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            trig_en       <= trigger_enable | conf.conf_enable;
            limit_reached <= (cnt >= conf.cnt_max) && (conf.cnt_max != '0);
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
                if (trig_edge && trig_en && !limit_reached && !veto)
                    state_next = st_accept;
            st_accept:
                state_next = st_wait_ack;
            st_wait_ack:
                if (trigger_acknowledge) // edges seen here are dropped
                    state_next = st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    // bus preset wins over an increment
    always_ff @(posedge BUS_CLK)
    begin
        if (sys_rst)
            cnt <= '0;
        else if (conf.cnt_set)
            cnt <= conf.cnt_set_value;
        else if (state == st_accept)
            cnt <= cnt + 1'b1;
    end

    assign trigger_accepted_flag = (state == st_accept);
    assign data_write            = (state == st_accept);
    assign data_word             = '{marker: 1'b1, count: cnt[30:0]};
    assign conf.cnt_value        = cnt;

endmodule

// ==== tlu_data_fifo.sv ====
// first-word-fall-through output fifo, counts writes refused while full
`timescale 1ns/10ps

module tlu_data_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic                BUS_CLK,
    input  logic                sys_rst,
    input  logic                write,
    input  tlu_pkg::data_word_t data_in,
    input  logic                read,
    output logic                empty,
    output tlu_pkg::data_word_t data_out,
    output tlu_pkg::bus_data_t  lost_count
);
    import tlu_pkg::*;

    localparam int aw = $clog2(fifo_depth);

    data_word_t mem [fifo_depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;  // occupancy
    logic          full;
    logic          do_write;
    logic          do_read;

    assign full     = (count == (aw+1)'(fifo_depth));
    assign empty    = (count == '0);
    assign do_write = write && !full;
    assign do_read  = read && !empty; // read on empty ignored

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (sys_rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1; // wraps at a power-of-two depth
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_write && !do_read)
                count <= count + 1'b1;
            else if (do_read && !do_write)
                count <= count - 1'b1;
            if (write && full && lost_count != 8'hff)
                lost_count <= lost_count + 1'b1; // saturates
        end
    end

    assign data_out = mem[rd_ptr];

endmodule

// ==== tlu_controller.sv ====
// trigger controller top level, connects register block, input path, FSM and fifo
`timescale 1ns/10ps

module tlu_controller #(
    parameter int fifo_depth = 8
) (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  tlu_pkg::bus_addr_t  bus_add,
    input  tlu_pkg::bus_data_t  bus_data_in,
    input  logic                bus_rd,
    input  logic                bus_wr,
    output tlu_pkg::bus_data_t  bus_data_out,
    input  tlu_pkg::trig_vec_t  trigger,
    input  tlu_pkg::trig_vec_t  trigger_veto,
    input  logic                trigger_enable,
    input  logic                trigger_acknowledge,
    output logic                trigger_accepted_flag,
    input  logic                fifo_read,
    output logic                fifo_empty,
    output tlu_pkg::data_word_t fifo_data
);
    import tlu_pkg::*;

    logic       sys_rst;   // RST or soft reset
    logic       trig_edge;
    logic       veto;
    logic       data_write;
    data_word_t data_word;
    bus_data_t  lost_count;

    tlu_conf_if conf_if ();

    tlu_bus_regs bus_regs_inst (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .lost_count   (lost_count),
        .bus_data_out (bus_data_out),
        .sys_rst      (sys_rst),
        .conf         (conf_if)
    );

    tlu_trigger_input trigger_input_inst (
        .BUS_CLK      (BUS_CLK),
        .sys_rst      (sys_rst),
        .trigger      (trigger),
        .trigger_veto (trigger_veto),
        .trig_edge    (trig_edge),
        .veto         (veto),
        .conf         (conf_if)
    );

    tlu_trigger_fsm trigger_fsm_inst (
        .BUS_CLK               (BUS_CLK),
        .sys_rst               (sys_rst),
        .trig_edge             (trig_edge),
        .veto                  (veto),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .trigger_accepted_flag (trigger_accepted_flag),
        .data_write            (data_write),
        .data_word             (data_word),
        .conf                  (conf_if)
    );

    tlu_data_fifo #(
        .fifo_depth (fifo_depth)
    ) data_fifo_inst (
        .BUS_CLK    (BUS_CLK),
        .sys_rst    (sys_rst),
        .write      (data_write),
        .data_in    (data_word),
        .read       (fifo_read),
        .empty      (fifo_empty),
        .data_out   (fifo_data),
        .lost_count (lost_count)
    );

endmodule

// ==== tlu_asserts.sv ====
// concurrent checks on the accept pulse of the trigger FSM, bound into tlu_trigger_fsm
`timescale 1ns/10ps

module tlu_asserts (
    input logic BUS_CLK,
    input logic sys_rst,
    input logic trig_edge,
    input logic veto,
    input logic trigger_accepted_flag,
    input logic data_write,
    input logic trigger_acknowledge
);

    logic waiting;   // between an accept and its acknowledge
    int   fails = 0; // failed assertions so far

    always_ff @(posedge BUS_CLK)
    begin
        if (sys_rst)
            waiting <= 1'b0;
        else if (trigger_accepted_flag)
            waiting <= 1'b1;
        else if (trigger_acknowledge)
            waiting <= 1'b0;
    end

    flag_one_cycle: assert property (@(posedge BUS_CLK) disable iff (sys_rst)
        trigger_accepted_flag |=> !trigger_accepted_flag)
        else
        begin
            fails++;
            $error("accepted flag high for more than one cycle");
        end

    // a word goes out only with the flag of an edge that passed the veto
    write_with_flag: assert property (@(posedge BUS_CLK) disable iff (sys_rst)
        (data_write || trigger_accepted_flag) |->
            (data_write && trigger_accepted_flag && $past(trig_edge && !veto)))
        else
        begin
            fails++;
            $error("fifo write not aligned with an accepted trigger edge");
        end

    // edges during the acknowledge wait are dropped
    no_accept_waiting: assert property (@(posedge BUS_CLK) disable iff (sys_rst)
        waiting |-> !trigger_accepted_flag)
        else
        begin
            fails++;
            $error("accept while waiting for acknowledge");
        end

endmodule

bind tlu_trigger_fsm tlu_asserts fsm_asserts_inst (
    .BUS_CLK               (BUS_CLK),
    .sys_rst               (sys_rst),
    .trig_edge             (trig_edge),
    .veto                  (veto),
    .trigger_accepted_flag (trigger_accepted_flag),
    .data_write            (data_write),
    .trigger_acknowledge   (trigger_acknowledge)
);

// ==== tb_tlu_controller.sv ====
// directed testbench for the trigger controller, run as top with the src.f file list
`timescale 1ns/10ps

module tb_tlu_controller;
    import tlu_pkg::*;

    localparam int fifo_depth     = 8;
    localparam int accept_timeout = 8; // cycles from input edge to accept, upper bound

    logic       BUS_CLK;
    logic       RST;
    bus_addr_t  bus_add;
    bus_data_t  bus_data_in;
    logic       bus_rd;
    logic       bus_wr;
    bus_data_t  bus_data_out;
    trig_vec_t  trigger;
    trig_vec_t  trigger_veto;
    logic       trigger_enable;
    logic       trigger_acknowledge;
    logic       trigger_accepted_flag;
    logic       fifo_read;
    logic       fifo_empty;
    data_word_t fifo_data;

    int          checks;
    int          errors;

    tlu_controller #(
        .fifo_depth (fifo_depth)
    ) tlu_controller_inst (
        .BUS_CLK               (BUS_CLK),
        .RST                   (RST),
        .bus_add               (bus_add),
        .bus_data_in           (bus_data_in),
        .bus_rd                (bus_rd),
        .bus_wr                (bus_wr),
        .bus_data_out          (bus_data_out),
        .trigger               (trigger),
        .trigger_veto          (trigger_veto),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .trigger_accepted_flag (trigger_accepted_flag),
        .fifo_read             (fifo_read),
        .fifo_empty            (fifo_empty),
        .fifo_data             (fifo_data)
    );

    initial
        BUS_CLK = 1'b0;
    always #10 BUS_CLK = ~BUS_CLK;

    // marker in bit 31, counter below it
    function automatic logic [31:0] expected_word(input logic [31:0] count);
        return {1'b1, count[30:0]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge BUS_CLK);
        #1;
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        @(posedge BUS_CLK);
        #1;
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        @(posedge BUS_CLK);
        #1;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_rd = 1'b0;
        data   = bus_data_out; // registered on the edge after bus_rd
    endtask

    task automatic soft_reset();
        bus_write(addr_version_rst, 8'h00);
    endtask

    task automatic read_counter(output logic [31:0] value);
        bus_data_t b0;
        bus_data_t b1;
        bus_data_t b2;
        bus_data_t b3;
        bus_read(addr_cnt0, b0); // latches the upper bytes
        bus_read(addr_cnt1, b1);
        bus_read(addr_cnt2, b2);
        bus_read(addr_cnt3, b3);
        value = {b3, b2, b1, b0};
    endtask

    task automatic set_trigger(input trig_vec_t value);
        @(posedge BUS_CLK);
        #1;
        trigger = value;
    endtask

    task automatic wait_accept(output bit got);
        int i;
        got = 1'b0;
        for (i = 0; i < accept_timeout && !got; i++)
        begin
            @(posedge BUS_CLK);
            #1;
            got = trigger_accepted_flag;
        end
    endtask

    // optionally pops the word and compares it
    task automatic expect_accept(input bit exp, input logic [31:0] word, input bit pop);
        bit got;
        wait_accept(got);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            if (exp)
                $display("Error at %0d ns: no accept within %0d cycles", $time, accept_timeout);
            else
                $display("Error at %0d ns: accept seen where none should occur", $time);
        end
        if (got && pop)
        begin
            @(posedge BUS_CLK);
            #1;
            check_value("fifo word", fifo_data, word);
            fifo_read = 1'b1;
            @(posedge BUS_CLK);
            #1;
            fifo_read = 1'b0;
        end
    endtask

    task automatic pulse_trigger(input bit exp, input logic [31:0] word, input bit pop);
        set_trigger(8'h01);
        expect_accept(exp, word, pop);
        set_trigger(8'h00);
        expect_accept(1'b0, 32'h0, 1'b0); // falling edge, also lets the input settle
    endtask

    task automatic register_readback();
        bus_addr_t   addrs [8];
        bus_data_t   vals [8];
        bus_data_t   rd;
        logic [31:0] r;
        int          i;
        check_value("bus_data_out after reset", 32'(bus_data_out), 32'h0);
        check_value("fifo_empty after reset", 32'(fifo_empty), 32'h1);
        check_value("accepted flag after reset", 32'(trigger_accepted_flag), 32'h0);
        bus_read(addr_version_rst, rd);
        check_value("version", 32'(rd), 32'h5);
        bus_read(addr_veto_sel, rd);
        check_value("veto select reset", 32'(rd), 32'hff);
        for (i = 2; i < 8; i++)
        begin
            bus_read(16'(i), rd);
            check_value($sformatf("unused address %0d", i), 32'(rd), 32'h0);
        end
        addrs = '{addr_conf, addr_trig_sel, addr_veto_sel, addr_trig_inv,
                  addr_max0, addr_max1, addr_max2, addr_max3};
        for (i = 0; i < 8; i++)
        begin
            r       = $urandom;
            vals[i] = r[7:0];
            bus_write(addrs[i], vals[i]);
        end
        for (i = 0; i < 8; i++)
        begin
            bus_read(addrs[i], rd);
            check_value($sformatf("register %0d", addrs[i]), 32'(rd), 32'(vals[i]));
        end
        soft_reset();
        for (i = 0; i < 8; i++)
        begin
            bus_read(addrs[i], rd);
            check_value($sformatf("register %0d after soft reset", addrs[i]), 32'(rd),
                        (addrs[i] == addr_veto_sel) ? 32'hff : 32'h0);
        end
    endtask

    task automatic select_invert_triggers();
        logic [31:0] r;
        logic [31:0] exp_cnt;
        logic [31:0] cnt_read;
        trig_vec_t   sel;
        trig_vec_t   inv;
        trig_vec_t   cur;
        trig_vec_t   nxt;
        bit          rise;
        int          step;
        trigger_enable = 1'b0;
        soft_reset();
        r   = $urandom;
        sel = r[7:0] | 8'h01; // at least one input selected
        inv = r[15:8];
        bus_write(addr_trig_sel, sel);
        bus_write(addr_trig_inv, inv);
        set_trigger(inv); // masked OR starts low
        cur = inv;
        idle_cycles(8);
        trigger_enable = 1'b1;
        idle_cycles(2);
        exp_cnt = 32'h0;
        for (step = 0; step < 16; step++)
        begin
            r         = $urandom;
            nxt       = cur;
            nxt[r[2:0]] = ~nxt[r[2:0]];
            rise      = !(|((cur ^ inv) & sel)) && (|((nxt ^ inv) & sel));
            set_trigger(nxt);
            cur = nxt;
            expect_accept(rise, expected_word(exp_cnt), 1'b1);
            if (rise)
                exp_cnt++;
        end
        read_counter(cnt_read);
        check_value("trigger counter", cnt_read, exp_cnt);
    endtask

    task automatic veto_and_ack();
        soft_reset();
        set_trigger(8'h00);
        bus_write(addr_trig_sel, 8'h01);
        trigger_veto = 8'h04; // selected by the all-ones reset mask
        idle_cycles(5);
        pulse_trigger(1'b0, 32'h0, 1'b0);
        trigger_veto = 8'h00;
        idle_cycles(5);
        trigger_acknowledge = 1'b0;
        set_trigger(8'h01);
        expect_accept(1'b1, expected_word(32'd0), 1'b1);
        set_trigger(8'h00);
        expect_accept(1'b0, 32'h0, 1'b0);
        set_trigger(8'h01); // second edge, still waiting for acknowledge
        expect_accept(1'b0, 32'h0, 1'b0);
        set_trigger(8'h00);
        expect_accept(1'b0, 32'h0, 1'b0);
        trigger_acknowledge = 1'b1;
        idle_cycles(3);
        pulse_trigger(1'b1, expected_word(32'd1), 1'b1);
        check_value("fifo_empty after veto test", 32'(fifo_empty), 32'h1);
    endtask

    task automatic counter_preset_limit();
        logic [31:0] r;
        logic [31:0] preset;
        logic [31:0] max_val;
        logic [31:0] cnt_read;
        int          k;
        soft_reset();
        bus_write(addr_trig_sel, 8'h01);
        r       = $urandom;
        preset  = {1'b0, r[30:4], 4'h0}; // room for the limit above it
        max_val = preset + 32'd3;
        bus_write(addr_cnt0, preset[7:0]);
        bus_write(addr_cnt1, preset[15:8]);
        bus_write(addr_cnt2, preset[23:16]);
        bus_write(addr_cnt3, preset[31:24]);
        bus_write(addr_max0, max_val[7:0]);
        bus_write(addr_max1, max_val[15:8]);
        bus_write(addr_max2, max_val[23:16]);
        bus_write(addr_max3, max_val[31:24]);
        for (k = 0; k < 6; k++)
            pulse_trigger(k < 3, expected_word(preset + 32'(k)), 1'b1);
        read_counter(cnt_read);
        check_value("counter at limit", cnt_read, max_val);
        bus_write(addr_max0, 8'h00);
        bus_write(addr_max1, 8'h00);
        bus_write(addr_max2, 8'h00);
        bus_write(addr_max3, 8'h00);
        pulse_trigger(1'b1, expected_word(max_val), 1'b1);
    endtask

    task automatic fifo_overflow();
        bus_data_t rd;
        int        k;
        soft_reset();
        bus_write(addr_trig_sel, 8'h01);
        for (k = 0; k < fifo_depth + 4; k++)
            pulse_trigger(1'b1, 32'h0, 1'b0);
        bus_read(addr_lost, rd);
        check_value("lost count", 32'(rd), 32'd4);
        for (k = 0; k < fifo_depth; k++)
        begin
            check_value("fifo_empty while draining", 32'(fifo_empty), 32'h0);
            check_value("drained word", fifo_data, expected_word(32'(k)));
            fifo_read = 1'b1;
            @(posedge BUS_CLK);
            #1;
        end
        fifo_read = 1'b0;
        check_value("fifo_empty after drain", 32'(fifo_empty), 32'h1);
    endtask

    initial
    begin
        void'($urandom(20205));
        checks              = 0;
        errors              = 0;
        RST                 = 1'b1;
        bus_add             = '0;
        bus_data_in         = '0;
        bus_rd              = 1'b0;
        bus_wr              = 1'b0;
        trigger             = '0;
        trigger_veto        = '0;
        trigger_enable      = 1'b0;
        trigger_acknowledge = 1'b1;
        fifo_read           = 1'b0;
        repeat (10) @(posedge BUS_CLK);
        #1;
        RST = 1'b0;
        register_readback();
        select_invert_triggers();
        veto_and_ack();
        counter_preset_limit();
        fifo_overflow();
        errors += tlu_controller_inst.trigger_fsm_inst.fsm_asserts_inst.fails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
tlu_pkg.sv
tlu_conf_if.sv
tlu_bus_regs.sv
tlu_trigger_input.sv
tlu_trigger_fsm.sv
tlu_data_fifo.sv
tlu_controller.sv
tlu_asserts.sv
tb_tlu_controller.sv

// ==== run.sh ====
#!/bin/sh
# build and run the trigger controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module tb_tlu_controller -o sim_tlu; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tlu)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
    exit 0
fi
exit 1
